// File: verilog/overlay_macros.svh
`ifndef OVERLAY_MACROS_SVH
`define OVERLAY_MACROS_SVH

// Box set
`define BOX_NUM    4
`define BOX_WIDTH  2
`define BOX_BYTES  6

// Active video size
`define H_ACT      1280
`define V_ACT      720

// Coordinate widths, enough for H_ACT and V_ACT
`define X_W        11
`define Y_W        10

`endif

// File: verilog/overlay_pkg.sv
`default_nettype none

`include "overlay_macros.svh"

package overlay_pkg;

    // One box record, written bytewise and read as fields
    typedef union packed {
        logic [0:`BOX_BYTES-1][7:0] bytes;
        struct packed {
            logic [3:0]       spare;
            logic [1:0]       color;
            logic [`X_W-1:0]  start_x;
            logic [`Y_W-1:0]  start_y;
            logic [`X_W-1:0]  end_x;
            logic [`Y_W-1:0]  end_y;
        } f;
    } box_rec_u;

    // Border colours by index
    localparam logic [23:0] PALETTE [4] = '{
        24'hFF_00_00,
        24'h00_FF_00,
        24'h00_00_FF,
        24'hFF_FF_00
    };

endpackage : overlay_pkg

`default_nettype wire

// File: verilog/pix_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

interface pix_if;

    logic              de;
    logic              hsync;
    logic              vsync;
    logic [23:0]       rgb;
    logic [`X_W-1:0]   x;
    logic [`Y_W-1:0]   y;

    modport source (
        output de, hsync, vsync, rgb, x, y
    );

    modport sink (
        input de, hsync, vsync, rgb, x, y
    );

endinterface : pix_if

`default_nettype wire

// File: verilog/udp_box_loader.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

module udp_box_loader (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_udp_valid,
    input  logic [7:0]            i_udp_data,
    output overlay_pkg::box_rec_u o_boxes [`BOX_NUM],
    output logic                  o_boxes_loaded
);

    import overlay_pkg::*;

    localparam int BOX_IDX_W  = $clog2(`BOX_NUM);
    localparam int BYTE_IDX_W = $clog2(`BOX_BYTES);

    logic [BOX_IDX_W-1:0]  box_idx;
    logic [BYTE_IDX_W-1:0] byte_idx;
    logic                  last_byte;

    box_rec_u stage      [`BOX_NUM];
    box_rec_u stage_next [`BOX_NUM];

    assign last_byte = (box_idx == BOX_IDX_W'(`BOX_NUM - 1)) &&
                       (byte_idx == BYTE_IDX_W'(`BOX_BYTES - 1));

    // Staging set with the current byte merged in
    always_comb begin
        stage_next = stage;
        if (i_udp_valid) begin
            stage_next[box_idx].bytes[byte_idx] = i_udp_data;
        end
    end

    always_ff @(posedge i_clk) begin
        stage <= stage_next;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            box_idx        <= '0;
            byte_idx       <= '0;
            o_boxes_loaded <= 1'b0;
            for (int i = 0; i < `BOX_NUM; i++) begin
                o_boxes[i] <= '0;
            end
        end else begin
            o_boxes_loaded <= 1'b0;
            if (i_udp_valid) begin
                if (byte_idx == BYTE_IDX_W'(`BOX_BYTES - 1)) begin
                    byte_idx <= '0;
                    box_idx  <= last_byte ? '0 : box_idx + 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
                // Whole set goes out at once
                if (last_byte) begin
                    o_boxes        <= stage_next;
                    o_boxes_loaded <= 1'b1;
                end
            end
        end
    end

endmodule : udp_box_loader

`default_nettype wire

// File: verilog/box_drawer.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

module box_drawer (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  overlay_pkg::box_rec_u i_box,
    pix_if.sink                   pix,
    output logic                  o_hit,
    output logic [23:0]           o_color
);

    import overlay_pkg::*;

    logic [`X_W:0] sx_in, x_in;
    logic [`Y_W:0] sy_in, y_in;
    logic          in_outer;
    logic          in_inner;

    // Inner bounds one bit wider so nothing wraps
    assign sx_in = {1'b0, i_box.f.start_x} + (`X_W+1)'(`BOX_WIDTH);
    assign sy_in = {1'b0, i_box.f.start_y} + (`Y_W+1)'(`BOX_WIDTH);
    assign x_in  = {1'b0, pix.x} + (`X_W+1)'(`BOX_WIDTH);
    assign y_in  = {1'b0, pix.y} + (`Y_W+1)'(`BOX_WIDTH);

    // An inverted box never passes the outer test
    assign in_outer = (pix.x >= i_box.f.start_x) && (pix.x <= i_box.f.end_x) &&
                      (pix.y >= i_box.f.start_y) && (pix.y <= i_box.f.end_y);

    assign in_inner = ({1'b0, pix.x} >= sx_in) && (x_in <= {1'b0, i_box.f.end_x}) &&
                      ({1'b0, pix.y} >= sy_in) && (y_in <= {1'b0, i_box.f.end_y});

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_hit <= 1'b0;
        end else begin
            o_hit <= pix.de && in_outer && !in_inner;
        end
    end

    always_ff @(posedge i_clk) begin
        o_color <= PALETTE[i_box.f.color];
    end

endmodule : box_drawer

`default_nettype wire

// File: verilog/box_overlay_mux.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

module box_overlay_mux (
    input  logic                       i_clk,
    input  logic                       i_rst,
    pix_if.sink                        pix_in,
    input  logic [`BOX_NUM-1:0]        i_hits,
    input  logic [`BOX_NUM-1:0][23:0]  i_colors,
    pix_if.source                      pix_out
);

    logic             de_d, hsync_d, vsync_d;
    logic [23:0]      rgb_d;
    logic [`X_W-1:0]  x_d;
    logic [`Y_W-1:0]  y_d;

    logic             any_hit;
    logic [23:0]      win_color;

    // Lowest box index wins
    always_comb begin
        any_hit   = 1'b0;
        win_color = '0;
        for (int i = `BOX_NUM - 1; i >= 0; i--) begin
            if (i_hits[i]) begin
                any_hit   = 1'b1;
                win_color = i_colors[i];
            end
        end
    end

    // Stage 1 lines up with the drawers
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            de_d    <= 1'b0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            de_d    <= pix_in.de;
            hsync_d <= pix_in.hsync;
            vsync_d <= pix_in.vsync;
        end
    end

    always_ff @(posedge i_clk) begin
        rgb_d <= pix_in.rgb;
        x_d   <= pix_in.x;
        y_d   <= pix_in.y;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pix_out.de    <= 1'b0;
            pix_out.hsync <= 1'b0;
            pix_out.vsync <= 1'b0;
        end else begin
            pix_out.de    <= de_d;
            pix_out.hsync <= hsync_d;
            pix_out.vsync <= vsync_d;
        end
    end

    always_ff @(posedge i_clk) begin
        pix_out.rgb <= any_hit ? win_color : rgb_d;
        pix_out.x   <= x_d;
        pix_out.y   <= y_d;
    end

endmodule : box_overlay_mux

`default_nettype wire

// File: verilog/box_overlay_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

module box_overlay_top (
    input  logic             i_clk,
    input  logic             i_rst,
    // Box bytes from the UDP receiver
    input  logic             i_udp_valid,
    input  logic [7:0]       i_udp_data,
    // Camera pixel pack
    input  logic             i_de,
    input  logic             i_hsync,
    input  logic             i_vsync,
    input  logic [23:0]      i_rgb,
    input  logic [`X_W-1:0]  i_x,
    input  logic [`Y_W-1:0]  i_y,
    // Overlaid pixel pack
    output logic             o_de,
    output logic             o_hsync,
    output logic             o_vsync,
    output logic [23:0]      o_rgb,
    output logic [`X_W-1:0]  o_x,
    output logic [`Y_W-1:0]  o_y,
    output logic             o_boxes_loaded
);

    import overlay_pkg::*;

    pix_if pix_cam ();
    pix_if pix_ovl ();

    box_rec_u                   boxes [`BOX_NUM];
    logic [`BOX_NUM-1:0]        hits;
    logic [`BOX_NUM-1:0][23:0]  colors;

    assign pix_cam.de    = i_de;
    assign pix_cam.hsync = i_hsync;
    assign pix_cam.vsync = i_vsync;
    assign pix_cam.rgb   = i_rgb;
    assign pix_cam.x     = i_x;
    assign pix_cam.y     = i_y;

    assign o_de    = pix_ovl.de;
    assign o_hsync = pix_ovl.hsync;
    assign o_vsync = pix_ovl.vsync;
    assign o_rgb   = pix_ovl.rgb;
    assign o_x     = pix_ovl.x;
    assign o_y     = pix_ovl.y;

    udp_box_loader u_loader (
        .i_clk         (i_clk         ),
        .i_rst         (i_rst         ),
        .i_udp_valid   (i_udp_valid   ),
        .i_udp_data    (i_udp_data    ),
        .o_boxes       (boxes         ),
        .o_boxes_loaded(o_boxes_loaded)
    );

    for (genvar i = 0; i < `BOX_NUM; i++) begin : g_box
        box_drawer u_drawer (
            .i_clk  (i_clk    ),
            .i_rst  (i_rst    ),
            .i_box  (boxes[i] ),
            .pix    (pix_cam  ),
            .o_hit  (hits[i]  ),
            .o_color(colors[i])
        );
    end

    box_overlay_mux u_mux (
        .i_clk   (i_clk  ),
        .i_rst   (i_rst  ),
        .pix_in  (pix_cam),
        .i_hits  (hits   ),
        .i_colors(colors ),
        .pix_out (pix_ovl)
    );

endmodule : box_overlay_top

`default_nettype wire

// File: test/box_overlay_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

module box_overlay_checker (
    input logic            i_clk,
    input logic            i_rst,
    input logic            i_udp_valid,
    input logic            i_de,
    input logic            i_hsync,
    input logic [`X_W-1:0] i_x,
    input logic            o_de,
    input logic            o_hsync,
    input logic [`X_W-1:0] o_x,
    input logic            o_boxes_loaded
);

    // Pack lags the input by two cycles
    a_de_lat: assert property (@(posedge i_clk) disable iff (i_rst)
        o_de == $past(i_de, 2)) else $error("o_de is not i_de delayed by two cycles");

    a_hsync_lat: assert property (@(posedge i_clk) disable iff (i_rst)
        o_hsync == $past(i_hsync, 2)) else $error("o_hsync is not delayed by two cycles");

    a_x_lat: assert property (@(posedge i_clk) disable iff (i_rst)
        o_x == $past(i_x, 2)) else $error("o_x is not i_x delayed by two cycles");

    a_load_after_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
        o_boxes_loaded |-> $past(i_udp_valid)) else $error("load pulse without a byte strobe");

    a_load_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        o_boxes_loaded |=> !o_boxes_loaded) else $error("load pulse longer than one cycle");

endmodule : box_overlay_checker

bind box_overlay_top box_overlay_checker u_checker (
    .i_clk, .i_rst, .i_udp_valid, .i_de, .i_hsync, .i_x,
    .o_de, .o_hsync, .o_x, .o_boxes_loaded
);

`default_nettype wire

// File: test/box_overlay_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "overlay_macros.svh"

module box_overlay_tb;

    localparam int NPIX  = 21;
    localparam int NSTEP = NPIX + 2;
    localparam int LIMIT = 16 + 4 + 2 * (`BOX_NUM * `BOX_BYTES + 2) + NPIX + 4 + 100;

    localparam logic [23:0] PAL [4] = '{24'hFF0000, 24'h00FF00, 24'h0000FF, 24'hFFFF00};

    // Per load: colour, start x, start y, end x, end y
    localparam int BOX_TBL [2][`BOX_NUM][5] = '{
        '{'{0, 100, 100, 200, 150}, '{1, 300, 300, 400, 400},
          '{2, 390, 390, 500, 500}, '{3, 600, 600, 500, 700}},
        '{'{3, 10, 10, 50, 50}, '{2, 700, 200, 800, 300},
          '{0, 0, 0, 0, 0}, '{0, 0, 0, 0, 0}}
    };

    // Load, x, y, de, winning box (-1 keeps camera rgb)
    localparam int PIX_TBL [NPIX][5] = '{
        '{0, 100, 100, 1, 0}, '{0, 200, 150, 1, 0}, '{0, 101, 120, 1, 0},
        '{0, 102, 120, 1, -1}, '{0, 199, 120, 1, 0}, '{0, 198, 120, 1, -1},
        '{0, 150, 101, 1, 0}, '{0, 150, 102, 1, -1}, '{0, 99, 120, 1, -1},
        '{0, 400, 390, 1, 1}, '{0, 500, 450, 1, 2}, '{0, 550, 650, 1, -1},
        '{0, 600, 600, 1, -1}, '{0, 100, 100, 0, -1}, '{0, 1000, 700, 1, -1},
        '{1, 100, 100, 1, -1}, '{1, 300, 300, 1, -1}, '{1, 10, 30, 1, 0},
        '{1, 12, 12, 1, -1}, '{1, 800, 250, 1, 1}, '{1, 500, 450, 1, -1}
    };

    string pix_name [NPIX] = '{
        "b0_start", "b0_end", "b0_sx_w1", "b0_sx_w", "b0_ex_w1", "b0_ex_w",
        "b0_sy_w1", "b0_sy_w", "b0_left_out", "b1_b2_overlap", "b2_end",
        "b3_inverted", "b3_start", "de_low_border", "far_out", "old_b0",
        "old_b1", "new_b0_edge", "new_b0_inner", "new_b1_end", "old_b2"
    };

    logic             clk;
    logic             rst;
    logic             udp_valid;
    logic [7:0]       udp_data;
    logic             de, hsync, vsync;
    logic [23:0]      rgb;
    logic [`X_W-1:0]  x;
    logic [`Y_W-1:0]  y;
    logic             o_de, o_hsync, o_vsync, o_boxes_loaded;
    logic [23:0]      o_rgb;
    logic [`X_W-1:0]  o_x;
    logic [`Y_W-1:0]  o_y;
    logic [15:0]      lfsr;
    int               errors;
    int               checks;
    int               cycles;

    box_overlay_top i_dut (
        .i_clk(clk), .i_rst(rst), .i_udp_valid(udp_valid), .i_udp_data(udp_data),
        .i_de(de), .i_hsync(hsync), .i_vsync(vsync), .i_rgb(rgb), .i_x(x), .i_y(y),
        .o_de(o_de), .o_hsync(o_hsync), .o_vsync(o_vsync), .o_rgb(o_rgb),
        .o_x(o_x), .o_y(o_y), .o_boxes_loaded(o_boxes_loaded)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic lfsr_step();
        logic b;
        b    = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
        return b;
    endfunction

    function automatic logic [23:0] random_bits(input int n);
        logic [23:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[22:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [47:0] pack_box(input int set, input int b);
        return {4'h0, 2'(BOX_TBL[set][b][0]), `X_W'(BOX_TBL[set][b][1]),
                `Y_W'(BOX_TBL[set][b][2]), `X_W'(BOX_TBL[set][b][3]),
                `Y_W'(BOX_TBL[set][b][4])};
    endfunction

    task automatic compare(input string name, input string field,
                           input logic [23:0] expected, input logic [23:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", name, field, expected, actual);
        end
    endtask

    task automatic load_boxes(input int set);
        logic [47:0] w;
        for (int b = 0; b < `BOX_NUM; b++) begin
            w = pack_box(set, b);
            for (int k = 0; k < `BOX_BYTES; k++) begin
                @(posedge clk);
                udp_valid <= 1'b1;
                udp_data  <= w[47 - 8 * k -: 8];
                @(negedge clk);
                compare("load_early", "boxes_loaded", 24'd0, 24'(o_boxes_loaded));
            end
        end
        @(posedge clk);
        udp_valid <= 1'b0;
        udp_data  <= 8'h00;
        @(negedge clk);
        compare("load_pulse", "boxes_loaded", 24'd1, 24'(o_boxes_loaded));
        @(negedge clk);
        compare("load_after", "boxes_loaded", 24'd0, 24'(o_boxes_loaded));
    endtask

    task automatic check_case(input int set, input int k, input logic [23:0] cam,
                              input logic hs, input logic vs);
        logic [23:0] exp_rgb;
        exp_rgb = cam;
        if (PIX_TBL[k][4] >= 0) begin
            exp_rgb = PAL[2'(BOX_TBL[set][PIX_TBL[k][4]][0])];
        end
        compare(pix_name[k], "de", 24'(PIX_TBL[k][3]), 24'(o_de));
        compare(pix_name[k], "hsync", 24'(hs), 24'(o_hsync));
        compare(pix_name[k], "vsync", 24'(vs), 24'(o_vsync));
        compare(pix_name[k], "rgb", exp_rgb, o_rgb);
        compare(pix_name[k], "x", 24'(PIX_TBL[k][1]), 24'(o_x));
        compare(pix_name[k], "y", 24'(PIX_TBL[k][2]), 24'(o_y));
    endtask

    // One new pixel per cycle, each checked two cycles later
    task automatic stream_pixels(input int set);
        int          idx [$];
        logic [23:0] cam [NSTEP];
        logic        hs  [NSTEP];
        logic        vs  [NSTEP];
        int          n;
        idx = {};
        for (int i = 0; i < NPIX; i++) begin
            if (PIX_TBL[i][0] == set) begin
                idx.push_back(i);
            end
        end
        n = idx.size();
        for (int j = 0; j < n + 2; j++) begin
            @(posedge clk);
            cam[j] = random_bits(24);
            hs[j]  = lfsr_step();
            vs[j]  = lfsr_step();
            rgb   <= cam[j];
            hsync <= hs[j];
            vsync <= vs[j];
            if (j < n) begin
                de <= 1'(PIX_TBL[idx[j]][3]);
                x  <= `X_W'(PIX_TBL[idx[j]][1]);
                y  <= `Y_W'(PIX_TBL[idx[j]][2]);
            end else begin
                de <= 1'b0;
                x  <= '0;
                y  <= '0;
            end
            @(negedge clk);
            if (j >= 2) begin
                check_case(set, idx[j - 2], cam[j - 2], hs[j - 2], vs[j - 2]);
            end
        end
    endtask

    initial begin
        lfsr      = 16'd5677;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        rst       = 1'b1;
        udp_valid = 1'b0;
        udp_data  = 8'h00;
        de        = 1'b0;
        hsync     = 1'b0;
        vsync     = 1'b0;
        rgb       = '0;
        x         = '0;
        y         = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            compare("idle", "de", 24'd0, 24'(o_de));
            compare("idle", "boxes_loaded", 24'd0, 24'(o_boxes_loaded));
        end
        load_boxes(0);
        stream_pixels(0);
        // Second set replaces the first
        load_boxes(1);
        stream_pixels(1);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : box_overlay_tb

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/overlay_pkg.sv
verilog/pix_if.sv
verilog/udp_box_loader.sv
verilog/box_drawer.sv
verilog/box_overlay_mux.sv
verilog/box_overlay_top.sv
test/box_overlay_checker.sv
test/box_overlay_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= box_overlay_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES) verilog/overlay_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
